/* hdl/memctl_pkg.sv */
// memory map, sizes, wait states and shared types, imported by every controller stage
package memctl_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [3:0]  ben_t;

   localparam int    ADDR_BITS     = 32;
   localparam int    SEG_MASK_BITS = 3;       // kuseg/kseg0/kseg1 select bits
   localparam ben_t  BEN_FULL      = 4'b1111;

   // main ram window, only RAM_WORDS actually stored
   localparam addr_t RAM_BASE  = 32'h0000_0000;
   localparam addr_t RAM_SPAN  = 32'h0020_0000; // 2 MB
   localparam int    RAM_WORDS = 1024;          // aliases every 4 KB

   // scratchpad window
   localparam addr_t SCR_BASE  = 32'h1F80_0000;
   localparam addr_t SCR_SPAN  = 32'h0000_0400; // 1 KB
   localparam int    SCR_WORDS = 256;

   // bios rom window
   localparam addr_t ROM_BASE  = 32'h1FC0_0000;
   localparam addr_t ROM_SPAN  = 32'h0008_0000; // 512 KB
   localparam int    ROM_WORDS = 16;            // aliases every 64 bytes
   localparam string ROM_FILE  = "bios.hex";

   // extra cycles for a main ram access, stands in for sdram latency
   localparam int RAM_WAIT  = 3;
   localparam int WAIT_BITS = $clog2(RAM_WAIT + 1);

   // word index carried from decoder to banks
   localparam int IDX_BITS     = 10;
   localparam int RAM_IDX_BITS = $clog2(RAM_WORDS);
   localparam int SCR_IDX_BITS = $clog2(SCR_WORDS);
   localparam int ROM_IDX_BITS = $clog2(ROM_WORDS);

   typedef logic [IDX_BITS-1:0] idx_t;

   typedef enum logic [1:0] {
      REG_RAM,
      REG_SCRATCH,
      REG_BIOS,
      REG_NONE
   } region_t;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } mem_op_t;

   typedef enum logic [2:0] {
      ARB_IDLE,
      ARB_BUSY_DATA,
      ARB_BUSY_INST,
      ARB_ACK_DATA,
      ARB_ACK_INST
   } arb_state_t;

endpackage

/* hdl/port_arbiter.sv */
// stage 1: picks data over instruction port, issues one access and hands back ack and data
module port_arbiter
   import memctl_pkg::*;
(
   input  logic    clk,
   input  logic    rst,

   // data port
   input  addr_t   data_addr_i,
   input  word_t   data_wdata_i,
   input  logic    data_ren_i,
   input  ben_t    data_wen_i,
   output logic    data_ack_o,
   output word_t   data_rdata_o,

   // instruction port
   input  addr_t   inst_addr_i,
   input  logic    inst_ren_i,
   output logic    inst_ack_o,
   output word_t   inst_rdata_o,

   // toward the address decoder
   output logic    req_start_o,
   output mem_op_t req_op_o,
   output addr_t   req_addr_o,
   output word_t   req_wdata_o,
   output ben_t    req_ben_o,

   // completion from the banks
   input  logic    acc_done_i,
   input  word_t   acc_rdata_i
);

   arb_state_t state;

   logic data_wen_any;
   logic data_req;
   logic take_data;
   logic take_inst;

   assign data_wen_any = |data_wen_i;               // any byte lane set means write
   assign data_req     = data_ren_i | data_wen_any;

   // data port always wins when both are waiting
   assign take_data = (state == ARB_IDLE) && data_req;
   assign take_inst = (state == ARB_IDLE) && !data_req && inst_ren_i;

   // captured request, held stable until the next grant
   always_ff @(posedge clk) begin
      if (take_data) begin
         req_op_o    <= data_wen_any ? OP_WRITE : OP_READ; // write wins over read
         req_addr_o  <= data_addr_i;
         req_wdata_o <= data_wdata_i;
         req_ben_o   <= data_wen_any ? data_wen_i : BEN_FULL;
      end else if (take_inst) begin
         req_op_o    <= OP_READ;
         req_addr_o  <= inst_addr_i;
         req_wdata_o <= '0;
         req_ben_o   <= BEN_FULL;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= ARB_IDLE;
         req_start_o  <= 1'b0;
         data_ack_o   <= 1'b0;
         inst_ack_o   <= 1'b0;
         data_rdata_o <= '0;
         inst_rdata_o <= '0;
      end else begin
         req_start_o <= take_data | take_inst;      // single pulse per grant

         case (state)
            ARB_IDLE: begin
               if (take_data) begin
                  state <= ARB_BUSY_DATA;
               end else if (take_inst) begin
                  state <= ARB_BUSY_INST;
               end
            end

            ARB_BUSY_DATA: begin
               if (acc_done_i) begin
                  data_rdata_o <= acc_rdata_i;
                  data_ack_o   <= 1'b1;
                  state        <= ARB_ACK_DATA;
               end
            end

            ARB_BUSY_INST: begin
               if (acc_done_i) begin
                  inst_rdata_o <= acc_rdata_i;
                  inst_ack_o   <= 1'b1;
                  state        <= ARB_ACK_INST;
               end
            end

            // hold ack until the requester lets go
            ARB_ACK_DATA: begin
               if (!data_req) begin
                  data_ack_o <= 1'b0;
                  state      <= ARB_IDLE;
               end
            end

            ARB_ACK_INST: begin
               if (!inst_ren_i) begin
                  inst_ack_o <= 1'b0;
                  state      <= ARB_IDLE;
               end
            end

            default: begin
               state <= ARB_IDLE;
            end
         endcase
      end
   end

endmodule

/* hdl/addr_decoder.sv */
// stage 2: strips segment bits, maps the physical address to a region and word index
module addr_decoder
   import memctl_pkg::*;
(
   input  logic    clk,
   input  logic    rst,

   input  logic    req_start_i,
   input  mem_op_t req_op_i,
   input  addr_t   req_addr_i,
   input  word_t   req_wdata_i,
   input  ben_t    req_ben_i,

   output logic    acc_start_o,
   output mem_op_t acc_op_o,
   output region_t acc_region_o,
   output idx_t    acc_index_o,
   output word_t   acc_wdata_o,
   output ben_t    acc_ben_o
);

   addr_t   phys;
   region_t region;
   idx_t    index;

   // all three cpu segments alias onto one physical map
   assign phys = {{SEG_MASK_BITS{1'b0}}, req_addr_i[ADDR_BITS-SEG_MASK_BITS-1:0]};

   // unsigned offset compare covers both window edges
   always_comb begin
      if (addr_t'(phys - RAM_BASE) < RAM_SPAN) begin
         region = REG_RAM;
      end else if (addr_t'(phys - SCR_BASE) < SCR_SPAN) begin
         region = REG_SCRATCH;
      end else if (addr_t'(phys - ROM_BASE) < ROM_SPAN) begin
         region = REG_BIOS;
      end else begin
         region = REG_NONE;                         // acked, reads zero
      end
   end

   assign index = phys[IDX_BITS+1:2];               // word address, banks take low bits

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_start_o <= 1'b0;
      end else begin
         acc_start_o <= req_start_i;
      end
   end

   // access fields stay put until the next request
   always_ff @(posedge clk) begin
      if (req_start_i) begin
         acc_op_o     <= req_op_i;
         acc_region_o <= region;
         acc_index_o  <= index;
         acc_wdata_o  <= req_wdata_i;
         acc_ben_o    <= req_ben_i;
      end
   end

endmodule

/* hdl/mem_banks.sv */
// stage 3: main ram, scratchpad and bios rom, performs one access and pulses done
module mem_banks
   import memctl_pkg::*;
(
   input  logic    clk,
   input  logic    rst,

   input  logic    acc_start_i,
   input  mem_op_t acc_op_i,
   input  region_t acc_region_i,
   input  idx_t    acc_index_i,
   input  word_t   acc_wdata_i,
   input  ben_t    acc_ben_i,

   output logic    acc_done_o,
   output word_t   acc_rdata_o
);

   word_t ram_mem [RAM_WORDS];
   word_t scr_mem [SCR_WORDS];
   word_t rom_mem [ROM_WORDS];

   logic                    ram_busy;
   logic [WAIT_BITS-1:0]    wait_cnt;
   logic                    fast_fire;
   logic                    ram_fire;
   logic                    fire;
   logic                    is_write;
   word_t                   rd_word;
   logic [RAM_IDX_BITS-1:0] ram_idx;
   logic [SCR_IDX_BITS-1:0] scr_idx;
   logic [ROM_IDX_BITS-1:0] rom_idx;

   initial begin
      $readmemh(ROM_FILE, rom_mem);
   end

   // each bank keeps only its low index bits, so addresses alias
   assign ram_idx = acc_index_i[RAM_IDX_BITS-1:0];
   assign scr_idx = acc_index_i[SCR_IDX_BITS-1:0];
   assign rom_idx = acc_index_i[ROM_IDX_BITS-1:0];

   assign is_write  = (acc_op_i == OP_WRITE);
   assign fast_fire = acc_start_i && (acc_region_i != REG_RAM); // single cycle regions
   assign ram_fire  = ram_busy && (wait_cnt == WAIT_BITS'(1));
   assign fire      = fast_fire | ram_fire;

   // ram wait counter, decoder fields are held while it runs
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ram_busy   <= 1'b0;
         wait_cnt   <= '0;
         acc_done_o <= 1'b0;
      end else begin
         acc_done_o <= fire;
         if (acc_start_i && (acc_region_i == REG_RAM)) begin
            ram_busy <= 1'b1;
            wait_cnt <= WAIT_BITS'(RAM_WAIT);
         end else if (ram_fire) begin
            ram_busy <= 1'b0;
         end else if (ram_busy) begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end
   end

   // writes and unmapped reads hand back zero
   always_comb begin
      rd_word = '0;
      if (!is_write) begin
         case (acc_region_i)
            REG_RAM:     rd_word = ram_mem[ram_idx];
            REG_SCRATCH: rd_word = scr_mem[scr_idx];
            REG_BIOS:    rd_word = rom_mem[rom_idx];
            default:     rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         acc_rdata_o <= rd_word;
      end
   end

   // main ram, byte lanes written at the end of the wait
   always_ff @(posedge clk) begin
      if (ram_fire && is_write) begin
         for (int b = 0; b < 4; b++) begin
            if (acc_ben_i[b]) begin
               ram_mem[ram_idx][8*b +: 8] <= acc_wdata_i[8*b +: 8];
            end
         end
      end
   end

   // scratchpad, same byte lane scheme
   always_ff @(posedge clk) begin
      if (fast_fire && is_write && (acc_region_i == REG_SCRATCH)) begin
         for (int b = 0; b < 4; b++) begin
            if (acc_ben_i[b]) begin
               scr_mem[scr_idx][8*b +: 8] <= acc_wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

/* hdl/mem_controller.sv */
// top level memory controller, serves the cpu data and instruction ports through three stages
module mem_controller
   import memctl_pkg::*;
(
   input  logic  clk,
   input  logic  rst,

   input  addr_t data_addr_i,
   input  word_t data_wdata_i,
   input  logic  data_ren_i,
   input  ben_t  data_wen_i,
   output logic  data_ack_o,
   output word_t data_rdata_o,

   input  addr_t inst_addr_i,
   input  logic  inst_ren_i,
   output logic  inst_ack_o,
   output word_t inst_rdata_o
);

   logic    req_start;
   mem_op_t req_op;
   addr_t   req_addr;
   word_t   req_wdata;
   ben_t    req_ben;

   logic    acc_start;
   mem_op_t acc_op;
   region_t acc_region;
   idx_t    acc_index;
   word_t   acc_wdata;
   ben_t    acc_ben;

   logic    acc_done;
   word_t   acc_rdata;

   port_arbiter i_port_arbiter (
      .clk          (clk),
      .rst          (rst),
      .data_addr_i  (data_addr_i),
      .data_wdata_i (data_wdata_i),
      .data_ren_i   (data_ren_i),
      .data_wen_i   (data_wen_i),
      .data_ack_o   (data_ack_o),
      .data_rdata_o (data_rdata_o),
      .inst_addr_i  (inst_addr_i),
      .inst_ren_i   (inst_ren_i),
      .inst_ack_o   (inst_ack_o),
      .inst_rdata_o (inst_rdata_o),
      .req_start_o  (req_start),
      .req_op_o     (req_op),
      .req_addr_o   (req_addr),
      .req_wdata_o  (req_wdata),
      .req_ben_o    (req_ben),
      .acc_done_i   (acc_done),
      .acc_rdata_i  (acc_rdata)
   );

   addr_decoder i_addr_decoder (
      .clk          (clk),
      .rst          (rst),
      .req_start_i  (req_start),
      .req_op_i     (req_op),
      .req_addr_i   (req_addr),
      .req_wdata_i  (req_wdata),
      .req_ben_i    (req_ben),
      .acc_start_o  (acc_start),
      .acc_op_o     (acc_op),
      .acc_region_o (acc_region),
      .acc_index_o  (acc_index),
      .acc_wdata_o  (acc_wdata),
      .acc_ben_o    (acc_ben)
   );

   mem_banks i_mem_banks (
      .clk          (clk),
      .rst          (rst),
      .acc_start_i  (acc_start),
      .acc_op_i     (acc_op),
      .acc_region_i (acc_region),
      .acc_index_i  (acc_index),
      .acc_wdata_i  (acc_wdata),
      .acc_ben_i    (acc_ben),
      .acc_done_o   (acc_done),
      .acc_rdata_o  (acc_rdata)
   );

endmodule

/* include/tb_vectors.svh */
// stimulus and expected words, included inside the testbench module after the package import
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// word k of the bios image, bios.hex holds the same values
localparam word_t TB_BIOS_IMAGE [ROM_WORDS] = '{
   32'h3C08_0013, 32'h3508_243F, 32'h3C01_1F80, 32'hAC28_1010,
   32'h240B_0B88, 32'h3C01_1F80, 32'hAC2B_1060, 32'h0000_0000,
   32'h0000_0000, 32'h3C0A_1F80, 32'h8D49_1070, 32'h0000_0000,
   32'h3C0B_BFC0, 32'h256B_0100, 32'h0160_0008, 32'h0000_0000
};

typedef struct packed {
   logic    port_inst;  // 0 data port, 1 instruction port
   mem_op_t op;
   addr_t   addr;
   ben_t    ben;
   word_t   wdata;
   word_t   exp;        // writes read back zero
   logic    with_inst;  // instruction read raised on the same edge
   addr_t   inst_addr;
   word_t   inst_exp;
} tb_vec_t;

localparam int TB_NUM_VECS = 19;

// unmapped write shares its low word bits with the scratchpad word read after it
localparam tb_vec_t TB_VECS [TB_NUM_VECS] = '{
   '{1'b0, OP_WRITE, 32'h1F80_0010, 4'b1111, 32'h1122_3344, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_WRITE, 32'h1F80_0010, 4'b0101, 32'hAABB_CCDD, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'h1F80_0010, 4'b0000, 32'h0, 32'h11BB_33DD, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_WRITE, 32'h0000_0020, 4'b1111, 32'hCAFE_F00D, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'h8000_0020, 4'b0000, 32'h0, 32'hCAFE_F00D, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'hA000_1020, 4'b0000, 32'h0, 32'hCAFE_F00D, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_WRITE, 32'h0000_0020, 4'b1100, 32'h1234_5678, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'h0000_0020, 4'b0000, 32'h0, 32'h1234_F00D, 1'b0, 32'h0, 32'h0},
   '{1'b1, OP_READ,  32'hBFC0_0000, 4'b0000, 32'h0, TB_BIOS_IMAGE[0], 1'b0, 32'h0, 32'h0},
   '{1'b1, OP_READ,  32'hBFC0_0004, 4'b0000, 32'h0, TB_BIOS_IMAGE[1], 1'b0, 32'h0, 32'h0},
   '{1'b1, OP_READ,  32'hBFC0_003C, 4'b0000, 32'h0, TB_BIOS_IMAGE[15], 1'b0, 32'h0, 32'h0},
   '{1'b1, OP_READ,  32'hBFC0_0040, 4'b0000, 32'h0, TB_BIOS_IMAGE[0], 1'b0, 32'h0, 32'h0},
   '{1'b1, OP_READ,  32'hBFC0_0044, 4'b0000, 32'h0, TB_BIOS_IMAGE[1], 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_WRITE, 32'hBFC0_0004, 4'b1111, 32'hDEAD_BEEF, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'hBFC0_0004, 4'b0000, 32'h0, TB_BIOS_IMAGE[1], 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'h1F00_0000, 4'b0000, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_WRITE, 32'h1F00_0010, 4'b1111, 32'hFFFF_FFFF, 32'h0, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'h1F80_0010, 4'b0000, 32'h0, 32'h11BB_33DD, 1'b0, 32'h0, 32'h0},
   '{1'b0, OP_READ,  32'h0000_0020, 4'b0000, 32'h0, 32'h1234_F00D,
     1'b1, 32'hBFC0_0008, TB_BIOS_IMAGE[2]}
};

`endif

/* test/tb_mem_controller.sv */
// testbench for the memory controller, applies the vector table and checks every acknowledged word
module tb_mem_controller
   import memctl_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   `include "tb_vectors.svh"

   localparam int CLK_PERIOD      = 8;
   localparam int RST_CYCLES      = 3;
   localparam int WATCHDOG_CYCLES = TB_NUM_VECS * (10 + RAM_WAIT) + 20;

   logic  clk;
   logic  rst;
   addr_t data_addr;
   word_t data_wdata;
   logic  data_ren;
   ben_t  data_wen;
   logic  data_ack;
   word_t data_rdata;
   addr_t inst_addr;
   logic  inst_ren;
   logic  inst_ack;
   word_t inst_rdata;

   mem_controller i_mem_controller (
      .clk          (clk),
      .rst          (rst),
      .data_addr_i  (data_addr),
      .data_wdata_i (data_wdata),
      .data_ren_i   (data_ren),
      .data_wen_i   (data_wen),
      .data_ack_o   (data_ack),
      .data_rdata_o (data_rdata),
      .inst_addr_i  (inst_addr),
      .inst_ren_i   (inst_ren),
      .inst_ack_o   (inst_ack),
      .inst_rdata_o (inst_rdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("mismatch at %0t ns: %s", $time, msg);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_error(input string msg);
      $display("error at %0t ns: %s", $time, msg);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input int idx, input string what, input word_t got,
                             input word_t exp);
      assert (got === exp) else begin
         report_mismatch($sformatf("entry %0d %s rdata %h, expected %h", idx, what, got, exp));
      end
   endtask

   task automatic raise_request(input tb_vec_t v);
      if (v.port_inst) begin
         inst_addr = v.addr;
         inst_ren  = 1'b1;
      end else begin
         data_addr  = v.addr;
         data_wdata = v.wdata;
         data_ren   = (v.op == OP_READ);
         data_wen   = (v.op == OP_WRITE) ? v.ben : 4'b0000; // nonzero mask means write
      end
      if (v.with_inst) begin
         inst_addr = v.inst_addr;                  // competes on the same edge
         inst_ren  = 1'b1;
      end
   endtask

   // outputs only move on rising edges, so falling edges are safe to sample
   task automatic wait_ack(input int idx, input logic on_inst, input logic watch_inst);
      logic ack;
      ack = 1'b0;
      while (!ack) begin
         @(negedge clk);
         ack = on_inst ? inst_ack : data_ack;
         if (watch_inst) begin
            assert (!inst_ack) else begin
               report_mismatch($sformatf("entry %0d inst ack rose before data ack", idx));
            end
         end
      end
   endtask

   task automatic drop_request(input int idx, input logic on_inst);
      if (on_inst) begin
         inst_ren = 1'b0;
      end else begin
         data_ren = 1'b0;
         data_wen = 4'b0000;
      end
      @(negedge clk);
      assert (on_inst ? !inst_ack : !data_ack) else begin
         report_mismatch($sformatf("entry %0d ack still high after request dropped", idx));
      end
   endtask

   task automatic run_entry(input int idx, input tb_vec_t v);
      assert (!data_ack && !inst_ack) else begin
         report_error($sformatf("entry %0d found an ack high before its request", idx));
      end
      raise_request(v);
      wait_ack(idx, v.port_inst, v.with_inst);
      if (v.port_inst) begin
         check_word(idx, "inst", inst_rdata, v.exp);
      end else begin
         check_word(idx, "data", data_rdata, v.exp);
      end
      drop_request(idx, v.port_inst);
      if (v.with_inst) begin
         wait_ack(idx, 1'b1, 1'b0);                // served once the data port lets go
         check_word(idx, "inst", inst_rdata, v.inst_exp);
         drop_request(idx, 1'b1);
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      data_addr  = '0;
      data_wdata = '0;
      data_ren   = 1'b0;
      data_wen   = 4'b0000;
      inst_addr  = '0;
      inst_ren   = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      assert (!data_ack && !inst_ack) else begin
         report_error("an ack was high right after reset");
      end
      for (int i = 0; i < TB_NUM_VECS; i++) begin
         run_entry(i, TB_VECS[i]);
      end
      $display("TB PASSED");
      $finish;
   end

   // budget per entry covers the slowest ram access plus handshake
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      report_error("watchdog expired, the controller never answered a request");
   end

endmodule

/* bios.hex */
// one 32-bit bios word per line in hex, word 0 first
3C080013
3508243F
3C011F80
AC281010
240B0B88
3C011F80
AC2B1060
00000000
00000000
3C0A1F80
8D491070
00000000
3C0BBFC0
256B0100
01600008
00000000

/* sim.f */
+incdir+include
hdl/memctl_pkg.sv
hdl/port_arbiter.sv
hdl/addr_decoder.sv
hdl/mem_banks.sv
hdl/mem_controller.sv
test/tb_mem_controller.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps -Wno-fatal \
   --top-module tb_mem_controller -f sim.f -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
